/* design/tank_pkg.sv */
//**********************************************************************
// tank playfield definitions
// grid size, coordinates, facings, enemy layout and player spawn cell
//**********************************************************************

package tank_pkg;

	localparam int GRID_CELLS  = 32;
	localparam int NUM_ENEMIES = 4;

	typedef logic [4:0] coord_t;	// one axis, 0 to 31
	typedef logic [2:0] score_t;	// 0 to 4

	// UP lowers y, LEFT lowers x
	typedef enum logic [1:0] {UP, DOWN, LEFT, RIGHT} dir_t;

	localparam coord_t COORD_MAX = coord_t'(GRID_CELLS - 1);

	// enemies stand in one row near the top edge
	localparam coord_t ENEMY_X [NUM_ENEMIES] = '{5'd4, 5'd12, 5'd20, 5'd28};
	localparam coord_t ENEMY_Y [NUM_ENEMIES] = '{5'd4, 5'd4, 5'd4, 5'd4};

	localparam coord_t SPAWN_X   = 5'd16;
	localparam coord_t SPAWN_Y   = 5'd28;
	localparam dir_t   SPAWN_DIR = UP;

	// next cell in direction d and whether it is still on the grid
	function automatic logic step_cell(
		input  coord_t x,
		input  coord_t y,
		input  dir_t   d,
		output coord_t nx,
		output coord_t ny
	);
		logic ok;
		nx = x;
		ny = y;
		case (d)
			UP:
			begin
				ok = (y != 5'd0);
				ny = y - 5'd1;
			end
			DOWN:
			begin
				ok = (y != COORD_MAX);
				ny = y + 5'd1;
			end
			LEFT:
			begin
				ok = (x != 5'd0);
				nx = x - 5'd1;
			end
			default:
			begin
				ok = (x != COORD_MAX);
				nx = x + 5'd1;
			end
		endcase
		return ok;
	endfunction

endpackage

/* design/button_sync.sv */
//**********************************************************************
// button synchronizer
// two-flop sync per button, held levels and one-cycle press pulses
//**********************************************************************

`timescale 1ns/10ps

module button_sync
(
	input  logic clk_100M,
	input  logic arst_n,
	input  logic btn_up,
	input  logic btn_down,
	input  logic btn_left,
	input  logic btn_right,
	input  logic btn_fire,
	input  logic btn_start,
	output logic up_held,
	output logic down_held,
	output logic left_held,
	output logic right_held,
	output logic move_press,
	output logic fire_press,
	output logic start_press
);

	logic [5:0] btn_raw;
	logic [5:0] sync_1;
	logic [5:0] sync_2;
	logic [5:0] prev;	// last synced value
	logic [5:0] rise;

	// bit order start fire right left down up
	assign btn_raw = {btn_start, btn_fire, btn_right, btn_left, btn_down, btn_up};
	assign rise    = sync_2 & ~prev;

	always_ff @(posedge clk_100M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sync_1      <= '0;
			sync_2      <= '0;
			prev        <= '0;
			move_press  <= 1'b0;
			fire_press  <= 1'b0;
			start_press <= 1'b0;
		end
		else
		begin
			sync_1      <= btn_raw;
			sync_2      <= sync_1;
			prev        <= sync_2;
			move_press  <= |rise[3:0];	// any direction
			fire_press  <= rise[4];
			start_press <= rise[5];
		end
	end

	assign up_held    = sync_2[0];
	assign down_held  = sync_2[1];
	assign left_held  = sync_2[2];
	assign right_held = sync_2[3];

endmodule

/* design/game_mode.sv */
//**********************************************************************
// round state machine
// idle until start, playing until every enemy is gone, then over
//**********************************************************************

`timescale 1ns/10ps

module game_mode
(
	input  logic                             clk_100M,
	input  logic                             arst_n,
	input  logic                             start_press,
	input  logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive,
	output logic                             playing,
	output logic                             game_over,
	output logic                             round_start
);

	typedef enum logic [1:0] {IDLE, PLAY, OVER} state_t;

	state_t state;

	always_ff @(posedge clk_100M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= IDLE;
			round_start <= 1'b0;
		end
		else
		begin
			round_start <= 1'b0;
			case (state)
				IDLE, OVER:
				begin
					if (start_press)
					begin
						state       <= PLAY;
						round_start <= 1'b1;
					end
				end
				PLAY:
				begin
					// flags are still clear while round_start is out
					if (!round_start && enemy_alive == '0)
						state <= OVER;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	assign playing   = (state == PLAY);
	assign game_over = (state == OVER);

endmodule

/* design/player_tank.sv */
//**********************************************************************
// player tank
// turns and moves one cell per press, blocked by the edge and by
// living enemies
//**********************************************************************

`timescale 1ns/10ps

module player_tank
(
	input  logic                             clk_100M,
	input  logic                             arst_n,
	input  logic                             playing,
	input  logic                             round_start,
	input  logic                             move_press,
	input  logic                             up_held,
	input  logic                             down_held,
	input  logic                             left_held,
	input  logic                             right_held,
	input  logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive,
	output tank_pkg::coord_t                 tank_x,
	output tank_pkg::coord_t                 tank_y,
	output tank_pkg::dir_t                   tank_dir
);

	tank_pkg::dir_t   want_dir;
	logic             want_valid;
	tank_pkg::coord_t nx;
	tank_pkg::coord_t ny;
	logic             in_grid;
	logic             blocked;

	// up wins over down over left over right
	always_comb
	begin
		want_valid = 1'b1;
		want_dir   = tank_dir;
		if (up_held)
			want_dir = tank_pkg::UP;
		else if (down_held)
			want_dir = tank_pkg::DOWN;
		else if (left_held)
			want_dir = tank_pkg::LEFT;
		else if (right_held)
			want_dir = tank_pkg::RIGHT;
		else
			want_valid = 1'b0;	// released before the pulse
	end

	always_comb
	begin
		in_grid = tank_pkg::step_cell(tank_x, tank_y, want_dir, nx, ny);
		blocked = 1'b0;
		for (int i = 0; i < tank_pkg::NUM_ENEMIES; i++)
		begin
			if (enemy_alive[i] && nx == tank_pkg::ENEMY_X[i] && ny == tank_pkg::ENEMY_Y[i])
				blocked = 1'b1;
		end
	end

	always_ff @(posedge clk_100M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tank_x   <= tank_pkg::SPAWN_X;
			tank_y   <= tank_pkg::SPAWN_Y;
			tank_dir <= tank_pkg::SPAWN_DIR;
		end
		else if (round_start)
		begin
			tank_x   <= tank_pkg::SPAWN_X;
			tank_y   <= tank_pkg::SPAWN_Y;
			tank_dir <= tank_pkg::SPAWN_DIR;
		end
		else if (playing && move_press && want_valid)
		begin
			tank_dir <= want_dir;	// turn even when the move is refused
			if (in_grid && !blocked)
			begin
				tank_x <= nx;
				tank_y <= ny;
			end
		end
	end

endmodule

/* design/bullet.sv */
//**********************************************************************
// player bullet
// launched from the tank cell, steps one cell every BULLET_DIV clocks
// until it leaves the grid or strikes an enemy
//**********************************************************************

`timescale 1ns/10ps

module bullet
#(
	parameter int BULLET_DIV = 4
)
(
	input  logic             clk_100M,
	input  logic             arst_n,
	input  logic             playing,
	input  logic             round_start,
	input  logic             fire_press,
	input  tank_pkg::coord_t tank_x,
	input  tank_pkg::coord_t tank_y,
	input  tank_pkg::dir_t   tank_dir,
	input  logic             hit,
	output logic             bul_active,
	output tank_pkg::coord_t bul_x,
	output tank_pkg::coord_t bul_y
);

	localparam int CNT_W = $clog2(BULLET_DIV);

	logic [CNT_W-1:0] step_cnt;
	tank_pkg::dir_t   bul_dir;
	tank_pkg::coord_t nx;
	tank_pkg::coord_t ny;
	logic             in_grid;
	logic             step_due;
	logic             launch;

	assign step_due = (step_cnt == CNT_W'(BULLET_DIV - 1));
	assign launch   = fire_press && playing && !bul_active && !round_start;

	always_comb
	begin
		in_grid = tank_pkg::step_cell(bul_x, bul_y, bul_dir, nx, ny);
	end

	always_ff @(posedge clk_100M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bul_active <= 1'b0;
			step_cnt   <= '0;
		end
		else if (round_start || hit)
		begin
			bul_active <= 1'b0;
			step_cnt   <= '0;
		end
		else if (!bul_active)
		begin
			bul_active <= launch;
			step_cnt   <= '0;	// counter idles between shots
		end
		else if (step_due)
		begin
			step_cnt <= '0;
			if (!in_grid)
				bul_active <= 1'b0;	// would fly off the edge
		end
		else
			step_cnt <= step_cnt + 1'b1;
	end

	// position and heading
	always_ff @(posedge clk_100M)
	begin
		if (launch)
		begin
			bul_x   <= tank_x;
			bul_y   <= tank_y;
			bul_dir <= tank_dir;
		end
		else if (bul_active && step_due && in_grid && !hit)
		begin
			bul_x <= nx;
			bul_y <= ny;
		end
	end

endmodule

/* design/enemy_field.sv */
//**********************************************************************
// enemy field
// survival flags of the fixed enemies, bullet hit detection and score
//**********************************************************************

`timescale 1ns/10ps

module enemy_field
(
	input  logic                             clk_100M,
	input  logic                             arst_n,
	input  logic                             round_start,
	input  logic                             bul_active,
	input  tank_pkg::coord_t                 bul_x,
	input  tank_pkg::coord_t                 bul_y,
	output logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive,
	output logic                             hit,
	output tank_pkg::score_t                 score
);

	logic [tank_pkg::NUM_ENEMIES-1:0] strike;

	// at most one enemy per cell so strike is one-hot or zero
	always_comb
	begin
		for (int i = 0; i < tank_pkg::NUM_ENEMIES; i++)
		begin
			strike[i] = bul_active && enemy_alive[i]
				&& bul_x == tank_pkg::ENEMY_X[i]
				&& bul_y == tank_pkg::ENEMY_Y[i];
		end
	end

	always_ff @(posedge clk_100M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			enemy_alive <= '0;	// nobody on the field before a round
			hit         <= 1'b0;
			score       <= '0;
		end
		else if (round_start)
		begin
			enemy_alive <= '1;
			hit         <= 1'b0;
			score       <= '0;
		end
		else
		begin
			enemy_alive <= enemy_alive & ~strike;
			hit         <= |strike;
			if (|strike)
				score <= score + 3'd1;
		end
	end

endmodule

/* design/tank_game_top.sv */
//**********************************************************************
// tank game playfield top
// buttons, round control, player tank, bullet and enemy field
//**********************************************************************

`timescale 1ns/10ps

module tank_game_top
#(
	parameter int BULLET_DIV = 4	// clocks per bullet step
)
(
	input  logic                             clk_100M,
	input  logic                             arst_n,
	input  logic                             btn_up,
	input  logic                             btn_down,
	input  logic                             btn_left,
	input  logic                             btn_right,
	input  logic                             btn_fire,
	input  logic                             btn_start,
	output logic                             playing,
	output logic                             game_over,
	output tank_pkg::coord_t                 tank_x,
	output tank_pkg::coord_t                 tank_y,
	output tank_pkg::dir_t                   tank_dir,
	output logic                             bul_active,
	output tank_pkg::coord_t                 bul_x,
	output tank_pkg::coord_t                 bul_y,
	output logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive,
	output tank_pkg::score_t                 score
);

	logic up_held;
	logic down_held;
	logic left_held;
	logic right_held;
	logic move_press;
	logic fire_press;
	logic start_press;
	logic round_start;
	logic hit;

	button_sync u_button_sync
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.btn_up      (btn_up),
		.btn_down    (btn_down),
		.btn_left    (btn_left),
		.btn_right   (btn_right),
		.btn_fire    (btn_fire),
		.btn_start   (btn_start),
		.up_held     (up_held),
		.down_held   (down_held),
		.left_held   (left_held),
		.right_held  (right_held),
		.move_press  (move_press),
		.fire_press  (fire_press),
		.start_press (start_press)
	);

	game_mode u_game_mode
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.start_press (start_press),
		.enemy_alive (enemy_alive),
		.playing     (playing),
		.game_over   (game_over),
		.round_start (round_start)
	);

	player_tank u_player_tank
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.playing     (playing),
		.round_start (round_start),
		.move_press  (move_press),
		.up_held     (up_held),
		.down_held   (down_held),
		.left_held   (left_held),
		.right_held  (right_held),
		.enemy_alive (enemy_alive),
		.tank_x      (tank_x),
		.tank_y      (tank_y),
		.tank_dir    (tank_dir)
	);

	bullet #(
		.BULLET_DIV (BULLET_DIV)
	) u_bullet
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.playing     (playing),
		.round_start (round_start),
		.fire_press  (fire_press),
		.tank_x      (tank_x),
		.tank_y      (tank_y),
		.tank_dir    (tank_dir),
		.hit         (hit),
		.bul_active  (bul_active),
		.bul_x       (bul_x),
		.bul_y       (bul_y)
	);

	enemy_field u_enemy_field
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.round_start (round_start),
		.bul_active  (bul_active),
		.bul_x       (bul_x),
		.bul_y       (bul_y),
		.enemy_alive (enemy_alive),
		.hit         (hit),
		.score       (score)
	);

endmodule

/* bench/tank_game_asserts.sv */
//**********************************************************************
// tank game checker
// round, bullet and score properties watched on the playfield top
//**********************************************************************

`timescale 1ns/10ps

module tank_game_asserts
(
	input logic                             clk_100M,
	input logic                             arst_n,
	input logic                             playing,
	input logic                             game_over,
	input logic                             round_start,
	input logic                             bul_active,
	input logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive,
	input tank_pkg::score_t                 score
);

	// a shot only leaves the tank during a round
	bullet_in_round: assert property (@(posedge clk_100M) disable iff (!arst_n)
		$rose(bul_active) |-> $past(playing))
		else $error("bullet launched outside a round");

	// the round is over only once the field is empty
	round_over_clear: assert property (@(posedge clk_100M) disable iff (!arst_n)
		game_over |-> !playing && enemy_alive == '0)
		else $error("round over while playing or with enemies left");

	score_monotonic: assert property (@(posedge clk_100M) disable iff (!arst_n)
		(score < $past(score)) |-> $past(round_start))	// only a new round clears it
		else $error("score dropped without a round start");

endmodule

bind tank_game_top tank_game_asserts u_asserts
(
	.clk_100M    (clk_100M),
	.arst_n      (arst_n),
	.playing     (playing),
	.game_over   (game_over),
	.round_start (round_start),
	.bul_active  (bul_active),
	.enemy_alive (enemy_alive),
	.score       (score)
);

/* bench/tank_game_tb.sv */
//**********************************************************************
// tank game testbench
// runs the command lines of the stim file against the playfield top,
// presses buttons and checks the visible ports
//**********************************************************************

`timescale 1ns/10ps

module tank_game_tb;

	localparam int BULLET_DIV = 4;	// same value as handed to the DUT
	localparam int PRESS_HOLD = 6;
	localparam int PRESS_GAP  = 6;
	localparam int WAIT_MAX   = 64 * BULLET_DIV;

	typedef logic [8*16-1:0] word_t;	// one word of the stim file

	logic                             clk_100M = 1'b0;
	logic                             arst_n;
	logic                             btn_up;
	logic                             btn_down;
	logic                             btn_left;
	logic                             btn_right;
	logic                             btn_fire;
	logic                             btn_start;
	logic                             playing;
	logic                             game_over;
	tank_pkg::coord_t                 tank_x;
	tank_pkg::coord_t                 tank_y;
	tank_pkg::dir_t                   tank_dir;
	logic                             bul_active;
	tank_pkg::coord_t                 bul_x;
	tank_pkg::coord_t                 bul_y;
	logic [tank_pkg::NUM_ENEMIES-1:0] enemy_alive;
	tank_pkg::score_t                 score;

	int cycles;
	int limit;
	int test_errs;
	int tests_ok;
	int tests_bad;

	logic [tank_pkg::NUM_ENEMIES-1:0] alive_at_fire;	// field when the last shot went off
	logic                             bul_was_active = 1'b0;
	tank_pkg::dir_t                   shot_dir;
	int                               last_bx;
	int                               last_by;

	tank_game_top #(
		.BULLET_DIV (BULLET_DIV)
	) dut
	(
		.clk_100M    (clk_100M),
		.arst_n      (arst_n),
		.btn_up      (btn_up),
		.btn_down    (btn_down),
		.btn_left    (btn_left),
		.btn_right   (btn_right),
		.btn_fire    (btn_fire),
		.btn_start   (btn_start),
		.playing     (playing),
		.game_over   (game_over),
		.tank_x      (tank_x),
		.tank_y      (tank_y),
		.tank_dir    (tank_dir),
		.bul_active  (bul_active),
		.bul_x       (bul_x),
		.bul_y       (bul_y),
		.enemy_alive (enemy_alive),
		.score       (score)
	);

	always #5 clk_100M = ~clk_100M;

	// run guard, limit comes from the stim file length
	always @(posedge clk_100M)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// a shot starts on the tank cell, then advances one cell at a time
	always @(negedge clk_100M)
	begin
		int nx;
		int ny;
		if (bul_active && !bul_was_active)
		begin
			check_val("bul_x", int'(bul_x), int'(tank_x));
			check_val("bul_y", int'(bul_y), int'(tank_y));
			shot_dir = tank_dir;
		end
		else if (bul_active && (int'(bul_x) != last_bx || int'(bul_y) != last_by))
		begin
			neighbour(last_bx, last_by, shot_dir, nx, ny);
			check_val("bul_x", int'(bul_x), nx);
			check_val("bul_y", int'(bul_y), ny);
		end
		bul_was_active = bul_active;
		last_bx        = int'(bul_x);
		last_by        = int'(bul_y);
	end

	// next cell along a facing, may lie off the grid
	function automatic void neighbour(
		input  int             x,
		input  int             y,
		input  tank_pkg::dir_t d,
		output int             nx,
		output int             ny
	);
		nx = x;
		ny = y;
		case (d)
			tank_pkg::UP:    ny = y - 1;
			tank_pkg::DOWN:  ny = y + 1;
			tank_pkg::LEFT:  nx = x - 1;
			default:         nx = x + 1;
		endcase
	endfunction

	// last shot rests on the grid edge or on the first living enemy ahead
	task automatic verify_shot_end();
		int   ex;
		int   ey;
		int   nx;
		int   ny;
		logic stop;
		ex   = int'(tank_x);
		ey   = int'(tank_y);
		stop = 1'b0;
		while (!stop)
		begin
			neighbour(ex, ey, tank_dir, nx, ny);
			if (nx < 0 || ny < 0 || nx >= tank_pkg::GRID_CELLS || ny >= tank_pkg::GRID_CELLS)
				stop = 1'b1;
			else
			begin
				ex = nx;
				ey = ny;
				for (int i = 0; i < tank_pkg::NUM_ENEMIES; i++)
				begin
					if (alive_at_fire[i] && ex == int'(tank_pkg::ENEMY_X[i])
						&& ey == int'(tank_pkg::ENEMY_Y[i]))
						stop = 1'b1;
				end
			end
		end
		check_val("bul_x", int'(bul_x), ex);
		check_val("bul_y", int'(bul_y), ey);
	endtask

	task automatic set_button(input word_t name, input logic level);
		case (name)
			word_t'("up"):    btn_up    = level;
			word_t'("down"):  btn_down  = level;
			word_t'("left"):  btn_left  = level;
			word_t'("right"): btn_right = level;
			word_t'("fire"):  btn_fire  = level;
			word_t'("start"): btn_start = level;
			default:
			begin
				$display("unknown button %0s in the stim file", name);
				test_errs++;
			end
		endcase
	endtask

	task automatic press_button(input word_t name, input int count);
		if (name == word_t'("fire"))
			alive_at_fire = enemy_alive;
		for (int i = 0; i < count; i++)
		begin
			set_button(name, 1'b1);
			repeat (PRESS_HOLD) @(negedge clk_100M);
			set_button(name, 1'b0);
			repeat (PRESS_GAP) @(negedge clk_100M);	// room for the next rising edge
		end
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic wait_bullet_done();
		int n;
		n = 0;
		while (bul_active && n < WAIT_MAX)
		begin
			@(negedge clk_100M);
			n++;
		end
		assert (!bul_active)
		else
		begin
			$display("bullet still in flight after %0d cycles", WAIT_MAX);
			test_errs++;
		end
		verify_shot_end();
	endtask

	task automatic wait_game_over();
		int n;
		n = 0;
		while (!game_over && n < WAIT_MAX)
		begin
			@(negedge clk_100M);
			n++;
		end
		assert (game_over)
		else
		begin
			$display("round did not end within %0d cycles", WAIT_MAX);
			test_errs++;
		end
		verify_shot_end();	// the winning shot
	endtask

	// first pass over the file, sizes the run guard
	task automatic count_commands(output int ncmd, output int nfire);
		int              sfd;
		int              rc;
		int              n;
		word_t           w;
		word_t           arg;
		logic [8*128-1:0] line;
		ncmd  = 0;
		nfire = 0;
		sfd   = $fopen("bench/tank_game_stim.txt", "r");
		if (sfd != 0)
		begin
			while ($fscanf(sfd, "%s", w) == 1)
			begin
				if (w == word_t'("press"))
				begin
					rc = $fscanf(sfd, "%s %d", arg, n);
					ncmd += n;
					if (arg == word_t'("fire"))
						nfire += n;
				end
				else if (w == word_t'("#") || w == word_t'("expect"))
				begin
					rc = $fgets(line, sfd);
					if (w != word_t'("#"))
						ncmd++;
				end
				else
					ncmd++;
			end
			$fclose(sfd);
		end
	endtask

	initial
	begin
		int              fd;
		int              rc;
		int              n;
		int              ncmd;
		int              nfire;
		int              ex;
		int              ey;
		int              ed;
		int              ea;
		int              es;
		int              ep;
		int              eo;
		word_t           cmd;
		word_t           arg;
		word_t           test_name;
		logic [8*128-1:0] line;

		arst_n    = 1'b0;
		btn_up    = 1'b0;
		btn_down  = 1'b0;
		btn_left  = 1'b0;
		btn_right = 1'b0;
		btn_fire  = 1'b0;
		btn_start = 1'b0;
		test_name = word_t'("none");
		count_commands(ncmd, nfire);
		limit = ncmd * 40 + 64 * BULLET_DIV * nfire;

		repeat (8) @(negedge clk_100M);
		arst_n = 1'b1;
		@(negedge clk_100M);

		fd = $fopen("bench/tank_game_stim.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file bench/tank_game_stim.txt");
			tests_bad++;
		end
		else
		begin
			while ($fscanf(fd, "%s", cmd) == 1)
			begin
				if (cmd == word_t'("#"))
					rc = $fgets(line, fd);	// column notes
				else if (cmd == word_t'("test"))
				begin
					rc = $fscanf(fd, "%s", test_name);
					test_errs = 0;
				end
				else if (cmd == word_t'("press"))
				begin
					rc = $fscanf(fd, "%s %d", arg, n);
					press_button(arg, n);
				end
				else if (cmd == word_t'("wait_bul"))
					wait_bullet_done();
				else if (cmd == word_t'("wait_over"))
					wait_game_over();
				else if (cmd == word_t'("expect"))
				begin
					rc = $fscanf(fd, "%h %h %h %h %h %h %h", ex, ey, ed, ea, es, ep, eo);
					check_val("tank_x", int'(tank_x), ex);
					check_val("tank_y", int'(tank_y), ey);
					check_val("tank_dir", int'(tank_dir), ed);
					check_val("enemy_alive", int'(enemy_alive), ea);
					check_val("score", int'(score), es);
					check_val("playing", int'(playing), ep);
					check_val("game_over", int'(game_over), eo);
				end
				else if (cmd == word_t'("end"))
				begin
					$display("test %0s done with %0d errors", test_name, test_errs);
					if (test_errs == 0)
						tests_ok++;
					else
						tests_bad++;
				end
				else
				begin
					$display("unknown command %0s in the stim file", cmd);
					tests_bad++;
				end
			end
			$fclose(fd);
		end

		$display("tests ok %0d, tests with errors %0d", tests_ok, tests_bad);
		if (tests_bad == 0 && tests_ok > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* bench/tank_game_stim.txt */
# commands: test <name> | press <button> <count> | wait_bul | wait_over | end
# expect <tank_x> <tank_y> <tank_dir> <enemy_alive> <score> <playing> <game_over> in hex
test reset
expect 10 1c 0 0 0 0 0
press start 1
expect 10 1c 0 f 0 1 0
end
test movement
press up 1
expect 10 1b 0 f 0 1 0
press down 1
expect 10 1c 1 f 0 1 0
press right 1
expect 11 1c 3 f 0 1 0
press left 1
expect 10 1c 2 f 0 1 0
press left 17
expect 00 1c 2 f 0 1 0
end
test blocking
press right 12
expect 0c 1c 3 f 0 1 0
press up 23
expect 0c 05 0 f 0 1 0
press right 1
press left 1
expect 0c 05 2 f 0 1 0
press up 1
expect 0c 05 0 f 0 1 0
end
test miss
press right 4
press up 1
expect 10 04 0 f 0 1 0
press fire 1
wait_bul
expect 10 04 0 f 0 1 0
end
test hits
press down 1
press left 4
press up 1
press fire 1
wait_bul
expect 0c 05 0 d 1 1 0
press left 8
press up 1
press fire 1
wait_bul
expect 04 05 0 c 2 1 0
press right 16
press up 1
press fire 1
wait_bul
expect 14 05 0 8 3 1 0
press right 8
press up 1
press fire 1
wait_over
expect 1c 05 0 0 4 0 1
end
test restart
press start 1
expect 10 1c 0 f 0 1 0
press left 4
press up 1
press fire 2
wait_bul
expect 0c 1b 0 d 1 1 0
end

/* tank_game_top.f */
design/tank_pkg.sv
design/button_sync.sv
design/game_mode.sv
design/player_tank.sv
design/bullet.sv
design/enemy_field.sv
design/tank_game_top.sv
bench/tank_game_asserts.sv
bench/tank_game_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the playfield testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tank_game_tb -f tank_game_top.f
./obj_dir/Vtank_game_tb | tee sim.log

if grep -q "Testbench passed" sim.log
then
	echo "simulation ok"
	exit 0
fi
echo "simulation reported errors"
exit 1
